/* hw/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Datapath width, shared by address and data
`define WORD_WIDTH 32

// Number of 32-bit words in the data memory
`define MEM_DEPTH 32

// log2 of MEM_DEPTH, width of the word index
`define INDEX_WIDTH 5

`endif

/* hw/memStagePkg.sv */
`default_nettype none

`include "mem_defines.svh"

package memStagePkg;

    // Encodings as issued by the decoder, 11 is never legal
    typedef enum logic [1:0] {
        sizeWord = 2'b00,   // lw / sw
        sizeHalf = 2'b01,   // lh / sh
        sizeByte = 2'b10    // lb / sb
    } accessSizeT;

    // Request from the execute stage
    typedef struct packed {
        logic [`WORD_WIDTH-1:0] address;    // Byte address, ALU result
        logic [`WORD_WIDTH-1:0] writeData;  // rs2 value for stores
        logic                   memRead;
        logic                   memWrite;
        accessSizeT             size;
        logic [4:0]             destReg;    // rd
        logic                   regWrite;
    } memReqT;

    // Entry handed to the writeback stage
    typedef struct packed {
        logic [`WORD_WIDTH-1:0] loadData;   // Sign-extended, zero on misaligned
        logic [4:0]             destReg;
        logic                   regWrite;
        logic                   isLoad;     // Low for stores and ALU ops
        logic                   misaligned; // Access was dropped
    } wbT;

    // Whole memory, word 0 in the low bits
    typedef logic [`MEM_DEPTH-1:0][`WORD_WIDTH-1:0] memImageT;

endpackage

`default_nettype wire

/* hw/pipeReg.sv */
`default_nettype none
`timescale 1ns/1ns

// Stage register, payload type chosen per instance
module pipeReg #(
    parameter type payloadT = logic
) (
    input  wire logic    Clock,
    input  wire logic    rst,
    input  wire logic    flush,     // Turns the incoming item into a bubble
    input  wire payloadT dataIn,
    input  wire logic    validIn,
    output payloadT      dataOut,
    output logic         validOut
);

    // Payload is don't-care while validOut is low
    always_ff @(posedge Clock) begin
        dataOut <= dataIn;
    end

    // Valid bit carries the control state
    always_ff @(posedge Clock) begin
        if (rst || flush) begin
            validOut <= 1'b0;   // Bubble
        end else begin
            validOut <= validIn;
        end
    end

endmodule

`default_nettype wire

/* hw/storeAlign.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mem_defines.svh"

// Store side address decode and lane steering
module storeAlign import memStagePkg::*; (
    input  wire memReqT                  request,
    input  wire logic                    requestValid,
    output logic [`INDEX_WIDTH-1:0]      wordIndex,
    output logic [3:0]                   byteEnable,
    output logic [`WORD_WIDTH-1:0]       laneData,
    output logic                         misaligned
);

    logic isAccess;     // Load or store
    logic halfOdd;
    logic badSize;
    logic outOfRange;   // Address past the last word
    logic writeEnable;
    logic [3:0] laneMask;

    assign wordIndex = request.address[`INDEX_WIDTH+1:2];

    assign isAccess   = request.memRead | request.memWrite;
    assign halfOdd    = (request.size == sizeHalf) && request.address[0];
    assign badSize    = (request.size == 2'b11);
    assign outOfRange = |request.address[`WORD_WIDTH-1:`INDEX_WIDTH+2];

    // Only real accesses get flagged
    assign misaligned = isAccess && (halfOdd || badSize || outOfRange);

    assign writeEnable = requestValid && request.memWrite && !misaligned;

    // Lane mask and replicated data per size
    always_comb begin
        laneMask = 4'b0000;
        laneData = '0;
        case (request.size)
            sizeWord: begin
                laneMask = 4'b1111;
                laneData = request.writeData;
            end
            sizeHalf: begin
                laneMask = request.address[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
                laneData = {2{request.writeData[15:0]}};
            end
            sizeByte: begin
                laneMask = 4'b0001 << request.address[1:0];
                laneData = {4{request.writeData[7:0]}};
            end
            default: ;  // Size 11, caught as misaligned
        endcase
    end

    assign byteEnable = writeEnable ? laneMask : 4'b0000;

endmodule

`default_nettype wire

/* hw/loadExtend.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mem_defines.svh"

// Load lane select and sign extension
module loadExtend import memStagePkg::*; (
    input  wire logic [`WORD_WIDTH-1:0] readWord,
    input  wire logic [1:0]             addressLow,
    input  wire accessSizeT             size,
    input  wire logic                   misaligned,
    output logic [`WORD_WIDTH-1:0]      loadData
);

    logic [7:0]  byteLane;
    logic [15:0] halfLane;

    // Byte lane by address low bits
    always_comb begin
        case (addressLow)
            2'b00:   byteLane = readWord[7:0];
            2'b01:   byteLane = readWord[15:8];
            2'b10:   byteLane = readWord[23:16];
            default: byteLane = readWord[31:24];
        endcase
    end

    // Bit 0 is never set here for a legal half access
    assign halfLane = addressLow[1] ? readWord[31:16] : readWord[15:0];

    always_comb begin
        if (misaligned) begin
            loadData = '0;  // Dropped access loads zero
        end else begin
            case (size)
                sizeWord: loadData = readWord;
                sizeHalf: loadData = {{(`WORD_WIDTH-16){halfLane[15]}}, halfLane};
                sizeByte: loadData = {{(`WORD_WIDTH-8){byteLane[7]}}, byteLane};
                default:  loadData = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/dataMemory.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mem_defines.svh"

// Byte-enable data RAM with full clear and debug image
module dataMemory import memStagePkg::*; (
    input  wire logic                    Clock,
    input  wire logic                    rst,
    input  wire logic                    clearMem,   // Whole-array clear
    input  wire logic [`INDEX_WIDTH-1:0] wordIndex,
    input  wire logic [3:0]              byteEnable,
    input  wire logic [`WORD_WIDTH-1:0]  laneData,   // Already lane-steered
    output logic [`WORD_WIDTH-1:0]       readWord,
    output memImageT                     memImage
);

    logic [`WORD_WIDTH-1:0] mem [`MEM_DEPTH];

    // Clear wins over a store in the same cycle
    always_ff @(posedge Clock) begin
        if (rst || clearMem) begin
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                mem[i] <= '0;  // Every word, last one included
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (byteEnable[b]) begin
                    mem[wordIndex][8*b +: 8] <= laneData[8*b +: 8];
                end
            end
        end
    end

    // Asynchronous read, same index as the store
    assign readWord = mem[wordIndex];

    // Debug image, word j at bits 32*j up
    for (genvar j = 0; j < `MEM_DEPTH; j++) begin : genImage
        assign memImage[j] = mem[j];
    end

endmodule

`default_nettype wire

/* hw/memStage.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mem_defines.svh"

// MEM stage: EX/MEM register, data memory, MEM/WB register
module memStage import memStagePkg::*; (
    input  wire logic   Clock,
    input  wire logic   rst,
    input  wire logic   flush,          // From branch unit
    input  wire logic   clearMem,
    input  wire memReqT request,
    input  wire logic   requestValid,
    output wbT          writeback,
    output logic        writebackValid,
    output memImageT    memImage
);

    memReqT                  exMemReq;     // Request held in EX/MEM
    logic                    exMemValid;
    logic [`INDEX_WIDTH-1:0] wordIndex;
    logic [3:0]              byteEnable;
    logic [`WORD_WIDTH-1:0]  laneData;
    logic                    misaligned;
    logic [`WORD_WIDTH-1:0]  readWord;
    logic [`WORD_WIDTH-1:0]  loadData;
    wbT                      wbIn;         // MEM/WB input

    pipeReg #(.payloadT(memReqT)) exMemReg (
        .Clock(Clock), .rst(rst), .flush(flush),
        .dataIn(request), .validIn(requestValid),
        .dataOut(exMemReq), .validOut(exMemValid)
    );

    storeAlign aligner (
        .request(exMemReq), .requestValid(exMemValid),
        .wordIndex(wordIndex), .byteEnable(byteEnable),
        .laneData(laneData), .misaligned(misaligned)
    );

    dataMemory dataMem (
        .Clock(Clock), .rst(rst), .clearMem(clearMem),
        .wordIndex(wordIndex), .byteEnable(byteEnable), .laneData(laneData),
        .readWord(readWord), .memImage(memImage)
    );

    loadExtend extender (
        .readWord(readWord), .addressLow(exMemReq.address[1:0]),
        .size(exMemReq.size), .misaligned(misaligned),
        .loadData(loadData)
    );

    // Writeback entry, wiring only
    assign wbIn = '{
        loadData:   loadData,
        destReg:    exMemReq.destReg,
        regWrite:   exMemReq.regWrite,
        isLoad:     exMemReq.memRead,
        misaligned: misaligned
    };

    // No flush past this point
    pipeReg #(.payloadT(wbT)) memWbReg (
        .Clock(Clock), .rst(rst), .flush(1'b0),
        .dataIn(wbIn), .validIn(exMemValid),
        .dataOut(writeback), .validOut(writebackValid)
    );

endmodule

`default_nettype wire

/* bench/memStage_chk.sv */
`default_nettype none
`timescale 1ns/1ns

// Pipeline and memory properties of the MEM stage
module memStageChk import memStagePkg::*; (
    input wire logic     Clock,
    input wire logic     rst,
    input wire logic     flush,
    input wire logic     clearMem,
    input wire logic     storeValid,     // EX/MEM valid
    input wire logic     storeWrite,     // EX/MEM memWrite
    input wire logic     misaligned,
    input wire logic     writebackValid,
    input wire memImageT memImage
);

    // MEM/WB empty one cycle after reset
    wbLowAfterReset: assert property (@(posedge Clock) rst |=> !writebackValid)
        else $error("writebackValid high in the cycle after rst");

    // Dropped store must not touch the array
    imageStableOnMisaligned: assert property (@(posedge Clock)
        storeValid && storeWrite && misaligned && !rst && !clearMem |=> $stable(memImage))
        else $error("memImage changed after a misaligned store");

    // Bubble reaches MEM/WB two edges after the flush
    noWbAfterFlush: assert property (@(posedge Clock) flush |-> ##2 !writebackValid)
        else $error("writeback produced for a flushed request");

endmodule

bind memStage memStageChk checks (
    .Clock(Clock), .rst(rst), .flush(flush), .clearMem(clearMem),
    .storeValid(exMemValid), .storeWrite(exMemReq.memWrite),
    .misaligned(misaligned), .writebackValid(writebackValid), .memImage(memImage)
);

`default_nettype wire

/* bench/memStageScoreboard.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mem_defines.svh"

// Reference memory and result checker sampling just before each rising edge
module memStageScoreboard import memStagePkg::*; (
    input wire logic     Clock,
    input wire logic     rst,
    input wire logic     flush,
    input wire logic     clearMem,
    input wire memReqT   request,
    input wire logic     requestValid,
    input wire wbT       writeback,
    input wire logic     writebackValid,
    input wire memImageT memImage
);

    typedef struct packed {
        int unsigned            due;       // Edge at which MEM/WB is sampled
        memReqT                 req;
        logic                   expectWb;
        logic [`WORD_WIDTH-1:0] expLoad;
        logic                   expMis;
    } pendingT;

    pendingT                pending[$];
    string                  pendingNames[$];
    logic [`WORD_WIDTH-1:0] refMem [`MEM_DEPTH];
    memReqT                 stageReq;               // Model of EX/MEM
    logic                   stageValid = 1'b0;
    bit                     resetSeen = 1'b0;       // Array known from here on
    int unsigned            edgeCount = 0;
    int                     passCount = 0;
    int                     failCount = 0;

    // Issued before edge k+1, in MEM/WB after k+2, seen at k+3
    function automatic void expectResult(string name, memReqT req, logic expectWb,
                                         logic [`WORD_WIDTH-1:0] expLoad, logic expMis);
        pendingT p;
        p = '{edgeCount + 3, req, expectWb, expLoad, expMis};
        pending.push_back(p);
        pendingNames.push_back(name);
    endfunction

    function automatic int pendingCount();
        return pending.size();
    endfunction

    // Odd half, size 11 or past the last word
    function automatic logic dropped(memReqT req);
        return (req.memRead || req.memWrite) &&
               ((req.size == sizeHalf && req.address[0]) || req.size == 2'b11 ||
                req.address >= 4 * `MEM_DEPTH);
    endfunction

    task automatic checkResult(pendingT p, string name);
        wbT    expWb;
        wbT    actWb;
        string detail;
        detail = "";
        actWb  = writeback;
        if (!p.req.memRead) begin
            actWb.loadData = '0;  // A store carries no load value
        end
        expWb = '{p.expLoad, p.req.destReg, p.req.regWrite, p.req.memRead, p.expMis};
        if (!p.expectWb && writebackValid !== 1'b0) begin
            detail = $sformatf("[FAIL] %s expected writebackValid 0 actual %b",
                               name, writebackValid);
        end else if (p.expectWb && writebackValid !== 1'b1) begin
            detail = $sformatf("Test %s: no writeback arrived two cycles after issue", name);
        end else if (p.expectWb) begin
            if (actWb !== expWb) begin
                detail = $sformatf("[FAIL] %s expected %h actual %h", name, expWb, actWb);
            end
        end
        if (detail == "") begin
            passCount++;
            $display("[PASS] %s", name);
        end else begin
            failCount++;
            $display("%s", detail);
        end
    endtask

    // Store commits from EX/MEM unless a clear wins
    task automatic updateModel();
        int idx;
        if (rst || clearMem) begin
            foreach (refMem[i]) refMem[i] = '0;
        end else if (stageValid && stageReq.memWrite && !dropped(stageReq)) begin
            idx = stageReq.address >> 2;
            case (stageReq.size)
                sizeWord: refMem[idx] = stageReq.writeData;
                sizeHalf: refMem[idx][16 * stageReq.address[1] +: 16] = stageReq.writeData[15:0];
                default:  refMem[idx][8 * stageReq.address[1:0] +: 8] = stageReq.writeData[7:0];
            endcase
        end
        if (rst) resetSeen = 1'b1;
        stageValid = requestValid && !flush && !rst;
        stageReq   = request;
    endtask

    always @(posedge Clock) begin
        edgeCount++;
        if (resetSeen) begin
            for (int j = 0; j < `MEM_DEPTH; j++) begin
                if (memImage[j] !== refMem[j]) begin
                    failCount++;
                    $display("[FAIL] memImage word %0d expected %h actual %h",
                             j, refMem[j], memImage[j]);
                end
            end
        end
        if (pending.size() > 0 && pending[0].due == edgeCount) begin
            checkResult(pending.pop_front(), pendingNames.pop_front());
        end else if (resetSeen && writebackValid !== 1'b0) begin
            failCount++;  // Nothing was due here
            $display("Writeback arrived at edge %0d with no issued request due", edgeCount);
        end
        updateModel();
    end

endmodule

`default_nettype wire

/* bench/memStageTb.sv */
`default_nettype none
`timescale 1ns/1ns

`include "mem_defines.svh"

module memStageTb import memStagePkg::*; ();

    // One table row, its name kept alongside
    typedef struct packed {
        memReqT      req;
        logic        valid;
        logic        flush;
        logic        clear;
        logic        resetFirst;   // Drain, then pulse rst
        logic [31:0] expLoad;      // Loads only
        logic        expMis;
    } stimT;

    logic     Clock;
    logic     rst;
    logic     flush;
    logic     clearMem;
    memReqT   request;
    logic     requestValid;
    wbT       writeback;
    logic     writebackValid;
    memImageT memImage;

    stimT  stimTable[$];
    string stimNames[$];
    bit    timedOut = 1'b0;

    memStage UUT (.*);

    memStageScoreboard sb (.*);

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;  // 4 ns
    end

    function automatic memReqT makeReq(logic rd, logic [1:0] sz, logic [31:0] addr,
                                       logic [31:0] data);
        memReqT r;
        r.address   = addr;
        r.writeData = data;
        r.memRead   = rd;
        r.memWrite  = !rd;
        r.size      = accessSizeT'(sz);
        r.destReg   = rd ? 5'(stimTable.size() % 31 + 1) : 5'd0;  // Loads write rd
        r.regWrite  = rd;
        return r;
    endfunction

    task automatic pushRow(string name, memReqT req, logic valid, logic fl, logic clr,
                           logic rstFirst, logic [31:0] expLoad, logic mis);
        stimT row;
        row = '{req, valid, fl, clr, rstFirst, expLoad, mis};
        stimTable.push_back(row);
        stimNames.push_back(name);
    endtask

    task automatic storeRow(string name, logic [1:0] sz, logic [31:0] addr, logic [31:0] data,
                            logic mis = 1'b0, logic fl = 1'b0);
        pushRow(name, makeReq(1'b0, sz, addr, data), 1'b1, fl, 1'b0, 1'b0, '0, mis);
    endtask

    task automatic loadRow(string name, logic [1:0] sz, logic [31:0] addr, logic [31:0] expLoad,
                           logic mis = 1'b0, logic fl = 1'b0, logic rstFirst = 1'b0);
        pushRow(name, makeReq(1'b1, sz, addr, '0), 1'b1, fl, 1'b0, rstFirst, expLoad, mis);
    endtask

    task automatic idleRow(string name, logic clr);
        pushRow(name, '0, 1'b0, 1'b0, clr, 1'b0, '0, 1'b0);
    endtask

    task automatic buildTable();
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            storeRow($sformatf("fill word %0d", i), sizeWord, 32'(4 * i), $urandom());
        end
        storeRow("sw w5", sizeWord, 32'h14, 32'h1234_5678);
        loadRow("lw w5 back-to-back", sizeWord, 32'h14, 32'h1234_5678);
        storeRow("sw w4", sizeWord, 32'h10, 32'h0F0F_0F0F);
        idleRow("gap", 1'b0);
        loadRow("lw w4 after gap", sizeWord, 32'h10, 32'h0F0F_0F0F);
        // Every lane negative in one word, positive in the other
        storeRow("sw w6", sizeWord, 32'h18, 32'h80FF_7F01);
        storeRow("sw w7", sizeWord, 32'h1C, 32'h7F00_81FF);
        loadRow("lb w6 lane 0", sizeByte, 32'h18, 32'h0000_0001);
        loadRow("lb w6 lane 1", sizeByte, 32'h19, 32'h0000_007F);
        loadRow("lb w6 lane 2", sizeByte, 32'h1A, 32'hFFFF_FFFF);
        loadRow("lb w6 lane 3", sizeByte, 32'h1B, 32'hFFFF_FF80);
        loadRow("lb w7 lane 0", sizeByte, 32'h1C, 32'hFFFF_FFFF);
        loadRow("lb w7 lane 1", sizeByte, 32'h1D, 32'hFFFF_FF81);
        loadRow("lb w7 lane 2", sizeByte, 32'h1E, 32'h0000_0000);
        loadRow("lb w7 lane 3", sizeByte, 32'h1F, 32'h0000_007F);
        loadRow("lh w6 lower", sizeHalf, 32'h18, 32'h0000_7F01);
        loadRow("lh w6 upper", sizeHalf, 32'h1A, 32'hFFFF_80FF);
        loadRow("lh w7 lower", sizeHalf, 32'h1C, 32'hFFFF_81FF);
        loadRow("lh w7 upper", sizeHalf, 32'h1E, 32'h0000_7F00);
        // Partial stores, other bytes checked through memImage
        storeRow("sw w8", sizeWord, 32'h20, 32'h1122_3344);
        storeRow("sb w8 lane 1", sizeByte, 32'h21, 32'hFFFF_FFEE);
        storeRow("sh w8 upper", sizeHalf, 32'h22, 32'h0000_BEEF);
        loadRow("lw w8 merged", sizeWord, 32'h20, 32'hBEEF_EE44);
        storeRow("sb w0 lane 2", sizeByte, 32'h02, 32'h0000_005A);
        storeRow("sh w1 lower", sizeHalf, 32'h04, 32'hFFFF_8001);
        loadRow("lb w0 lane 2", sizeByte, 32'h02, 32'h0000_005A);
        storeRow("sh odd address", sizeHalf, 32'h21, 32'h0000_FFFF, 1'b1);
        loadRow("lh odd address", sizeHalf, 32'h23, '0, 1'b1);
        storeRow("store size 11", 2'b11, 32'h20, 32'hDEAD_BEEF, 1'b1);
        loadRow("load size 11", 2'b11, 32'h20, '0, 1'b1);
        storeRow("sw beyond depth", sizeWord, 32'h80, 32'hFFFF_FFFF, 1'b1);
        loadRow("lw w8 unchanged", sizeWord, 32'h20, 32'hBEEF_EE44);
        storeRow("sw w9", sizeWord, 32'h24, 32'hCAFE_F00D);
        storeRow("sw w9 flushed", sizeWord, 32'h24, 32'h0BAD_BEEF, 1'b0, 1'b1);
        loadRow("lw w9 flushed", sizeWord, 32'h24, '0, 1'b0, 1'b1);
        loadRow("lw w9", sizeWord, 32'h24, 32'hCAFE_F00D);
        storeRow("sw w10 lost to clear", sizeWord, 32'h28, 32'h55AA_55AA);
        idleRow("clearMem", 1'b1);
        loadRow("lw w10 after clear", sizeWord, 32'h28, '0);
        loadRow("lw w6 after clear", sizeWord, 32'h18, '0);
        storeRow("sw w11", sizeWord, 32'h2C, 32'h1357_9BDF);
        loadRow("lw w11", sizeWord, 32'h2C, 32'h1357_9BDF);
        loadRow("lw w11 after rst", sizeWord, 32'h2C, '0, 1'b0, 1'b0, 1'b1);
    endtask

    task automatic driveIdle();
        request      = '0;
        requestValid = 1'b0;
        flush        = 1'b0;
        clearMem     = 1'b0;
    endtask

    // Until every issued row is checked
    task automatic waitDrain();
        int waited = 0;
        while (sb.pendingCount() > 0 && waited < 20) begin
            @(negedge Clock);
            waited++;
        end
        if (sb.pendingCount() > 0) begin
            $display("Timeout: no writeback arrived for %0d issued rows", sb.pendingCount());
            timedOut = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(50784));
        rst = 1'b1;
        driveIdle();
        buildTable();
        repeat (16) @(negedge Clock);
        rst = 1'b0;
        foreach (stimTable[i]) begin
            if (stimTable[i].resetFirst) begin
                @(negedge Clock);
                driveIdle();
                waitDrain();
                rst = 1'b1;
                repeat (2) @(negedge Clock);
                rst = 1'b0;
            end
            @(negedge Clock);
            request      = stimTable[i].req;
            requestValid = stimTable[i].valid;
            flush        = stimTable[i].flush;
            clearMem     = stimTable[i].clear;
            sb.expectResult(stimNames[i], stimTable[i].req,
                            stimTable[i].valid && !stimTable[i].flush,
                            stimTable[i].expLoad, stimTable[i].expMis);
        end
        @(negedge Clock);
        driveIdle();
        waitDrain();
        $display("Summary: %0d passed, %0d failed, %0d rows", sb.passCount, sb.failCount,
                 stimTable.size());
        if (sb.failCount == 0 && !timedOut && sb.passCount == stimTable.size()) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/memStagePkg.sv
hw/pipeReg.sv
hw/storeAlign.sv
hw/loadExtend.sv
hw/dataMemory.sv
hw/memStage.sv
bench/memStage_chk.sv
bench/memStageScoreboard.sv
bench/memStageTb.sv
